// ==== ci_controller.sv ====
`timescale 1ns/1ps

module ci_controller #(
    parameter int COLS = 19,
    parameter int ROWS = 19
) (
    input  logic clk,
    input  logic rst,
    input  logic col_valid_i,
    output logic band_clr_o,
    output logic win_full_o,
    output logic last_col_o,
    output logic progress_done_o
);
    import ci_geom_pkg::*;
    import ci_ctrl_pkg::*;

    localparam int BANDS   = ROWS - WIN + 1;
    localparam int COL_CW  = cnt_w(COLS);
    localparam int BAND_CW = cnt_w(BANDS);

    ctrl_state_e        state_q;
    logic [COL_CW-1:0]  col_cnt_q;
    logic [BAND_CW-1:0] band_cnt_q;
    logic               band_end_q;
    logic               accept;
    logic               col_last;
    logic               band_last;

    assign accept    = col_valid_i && (state_q != FINISHED);
    assign col_last  = (col_cnt_q == COL_CW'(COLS - 1));
    assign band_last = (band_cnt_q == BAND_CW'(BANDS - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // summer control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // idle covers the first band after reset.
    assign band_clr_o = (state_q == IDLE) || band_end_q;

    assign win_full_o = (state_q == RUN) ||
                        ((state_q != FINISHED) && (col_cnt_q == COL_CW'(WIN - 1)));

    assign last_col_o = (state_q != FINISHED) && band_last && col_last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // column and band counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= IDLE;
            col_cnt_q       <= '0;
            band_cnt_q      <= '0;
            band_end_q      <= 1'b0;
            progress_done_o <= 1'b0;
        end else begin
            band_end_q <= 1'b0;
            if (accept) begin
                if (col_last) begin
                    col_cnt_q  <= '0;
                    band_end_q <= 1'b1;              // next band starts empty.
                    if (band_last) begin
                        state_q         <= FINISHED;
                        progress_done_o <= 1'b1;     // held until reset.
                    end else begin
                        band_cnt_q <= band_cnt_q + 1'b1;
                        state_q    <= FILL;
                    end
                end else begin
                    col_cnt_q <= col_cnt_q + 1'b1;
                    if (col_cnt_q == COL_CW'(WIN - 1)) begin
                        state_q <= RUN;
                    end else if (state_q == IDLE) begin
                        state_q <= FILL;
                    end
                end
            end
        end
    end

    // a band clear never lands on a strobe that closes a window.
    a_clr_not_full : assert property (
        @(posedge clk) disable iff (rst)
        !(band_clr_o && win_full_o)
    );

endmodule

// ==== ci_ctrl_pkg.sv ====
package ci_ctrl_pkg;

    // band walk states.
    typedef enum logic [1:0] {
        IDLE,       // after reset, history is cleared.
        FILL,       // fewer than 17 columns seen in the band.
        RUN,        // every strobe completes a window.
        FINISHED    // last band done, strobes ignored.
    } ctrl_state_e;

    // bits needed to count 0 .. n-1, at least one.
    function automatic int cnt_w(input int n);
        int w;
        w = (n > 1) ? $clog2(n) : 1;
        return w;
    endfunction

endpackage

// ==== ci_geom_pkg.sv ====
package ci_geom_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel and window geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PIX_W      = 8;
    localparam int WIN        = 17;               // radius 8 window side.
    localparam int CENTER_IDX = (WIN - 1) / 2;
    localparam int WIN_AREA   = WIN * WIN;        // 289.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arithmetic widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SUM_W    = 17;                 // holds 289 * 255.
    localparam int COLSUM_W = 13;                 // holds 17 * 255.
    localparam int REM_W    = 9;                  // remainder below 289.
    localparam int QUO_W    = PIX_W;              // mean fits one pixel.

    // largest sum a window of full-scale pixels can reach.
    localparam int WIN_SUM_MAX = WIN_AREA * ((1 << PIX_W) - 1);

    typedef logic [PIX_W-1:0]    pixel_t;
    typedef logic [SUM_W-1:0]    sum_t;
    typedef logic [COLSUM_W-1:0] colsum_t;
    typedef logic [QUO_W-1:0]    quo_t;

    // index 0 is row 0 of the band.
    typedef pixel_t [WIN-1:0] column_t;

endpackage

// ==== ci_r8_top.sv ====
`timescale 1ns/1ps

module ci_r8_top #(
    parameter int COLS = 19,
    parameter int ROWS = 19
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 col_valid_i,
    input  ci_geom_pkg::column_t col_i,
    output logic                 ci_o,
    output logic                 ci_valid_o,
    output logic                 done_o,
    output logic                 progress_done_o
);

    logic band_clr;
    logic win_full;
    logic last_col;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // band and column walk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ci_controller #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .col_valid_i     (col_valid_i),
        .band_clr_o      (band_clr),
        .win_full_o      (win_full),
        .last_col_o      (last_col),
        .progress_done_o (progress_done_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // window sum and threshold
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    win_sum_if win_sum ();

    ci_window_sum u_sum (
        .clk         (clk),
        .rst         (rst),
        .col_valid_i (col_valid_i),
        .col_i       (col_i),
        .band_clr_i  (band_clr),
        .win_full_i  (win_full),
        .last_col_i  (last_col),
        .sum_o       (win_sum.src)
    );

    ci_threshold u_thr (
        .clk        (clk),
        .rst        (rst),
        .sum_i      (win_sum.dst),
        .ci_o       (ci_o),
        .ci_valid_o (ci_valid_o),
        .done_o     (done_o)
    );

endmodule

// ==== ci_threshold.sv ====
`timescale 1ns/1ps

module ci_threshold (
    input  logic   clk,
    input  logic   rst,
    win_sum_if.dst sum_i,
    output logic   ci_o,
    output logic   ci_valid_o,
    output logic   done_o
);
    import ci_geom_pkg::*;

    sum_t             rem_in [QUO_W];
    quo_t             quo_in [QUO_W];
    sum_t             rem_d  [QUO_W];
    quo_t             quo_d  [QUO_W];
    sum_t             rem_q  [QUO_W];
    quo_t             quo_q  [QUO_W];
    pixel_t           ctr_q  [QUO_W];
    logic [QUO_W-1:0] vld_q;
    logic [QUO_W-1:0] last_q;
    logic [REM_W-1:0] rem_fin;
    logic             flush;

    assign flush = rst || sum_i.clr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // restoring divider by 289
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stage s resolves quotient bit QUO_W-1-s.
    always_comb begin : div_step
        sum_t dvs;
        rem_in[0] = sum_i.sum;
        quo_in[0] = '0;
        for (int s = 1; s < QUO_W; s++) begin
            rem_in[s] = rem_q[s-1];
            quo_in[s] = quo_q[s-1];
        end
        for (int s = 0; s < QUO_W; s++) begin
            dvs      = sum_t'(WIN_AREA) << (QUO_W - 1 - s);
            quo_d[s] = quo_in[s];
            if (rem_in[s] >= dvs) begin
                rem_d[s]                 = rem_in[s] - dvs;
                quo_d[s][QUO_W - 1 - s] = 1'b1;
            end else begin
                rem_d[s] = rem_in[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < QUO_W; s++) begin
            rem_q[s] <= rem_d[s];
            quo_q[s] <= quo_d[s];
        end
        ctr_q[0] <= sum_i.center;            // center rides along with its window.
        for (int s = 1; s < QUO_W; s++) begin
            ctr_q[s] <= ctr_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            vld_q  <= '0;
            last_q <= '0;
        end else begin
            vld_q  <= {vld_q[QUO_W-2:0], sum_i.valid};
            last_q <= {last_q[QUO_W-2:0], sum_i.valid && sum_i.last};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ci compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rem_fin = rem_q[QUO_W-1][REM_W-1:0];

    always_ff @(posedge clk) begin
        ci_o <= (ctr_q[QUO_W-1] > quo_q[QUO_W-1]) ||
                ((ctr_q[QUO_W-1] == quo_q[QUO_W-1]) && (rem_fin == '0));
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            ci_valid_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            ci_valid_o <= vld_q[QUO_W-1];
            done_o     <= last_q[QUO_W-1];       // with the last window's ci.
        end
    end

    // all eight stages together must leave a proper remainder.
    a_rem_range : assert property (
        @(posedge clk) disable iff (rst)
        vld_q[QUO_W-1] |-> (rem_q[QUO_W-1] < sum_t'(WIN_AREA))
    );

endmodule

// ==== ci_window_sum.sv ====
`timescale 1ns/1ps

module ci_window_sum (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 col_valid_i,
    input  ci_geom_pkg::column_t col_i,
    input  logic                 band_clr_i,
    input  logic                 win_full_i,
    input  logic                 last_col_i,
    win_sum_if.src               sum_o
);
    import ci_geom_pkg::*;

    colsum_t col_sum;
    colsum_t hist_q [WIN];
    sum_t    win_sum_q;
    pixel_t  ctr_sh_q [CENTER_IDX+1];
    logic    valid_q;
    logic    last_q;
    logic    clr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // column sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        col_sum = '0;
        for (int r = 0; r < WIN; r++) begin
            col_sum = col_sum + colsum_t'(col_i[r]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // column history and window sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // hist_q[0] is the newest column, hist_q[WIN-1] leaves next.
    always_ff @(posedge clk) begin
        if (band_clr_i) begin
            for (int i = 1; i < WIN; i++) begin
                hist_q[i] <= '0;
            end
            hist_q[0] <= col_valid_i ? col_sum : '0;   // first column may come with the clear.
            win_sum_q <= col_valid_i ? sum_t'(col_sum) : '0;
        end else if (col_valid_i) begin
            hist_q[0] <= col_sum;
            for (int i = 1; i < WIN; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
            win_sum_q <= win_sum_q + sum_t'(col_sum) - sum_t'(hist_q[WIN-1]);
        end
    end

    // row-8 pixels, ctr_sh_q[CENTER_IDX] is the window center after a strobe.
    always_ff @(posedge clk) begin
        if (col_valid_i) begin
            ctr_sh_q[0] <= col_i[CENTER_IDX];
            for (int i = 1; i <= CENTER_IDX; i++) begin
                ctr_sh_q[i] <= ctr_sh_q[i-1];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            clr_q   <= 1'b1;                 // flush threshold once out of reset.
        end else begin
            valid_q <= col_valid_i && win_full_i;
            last_q  <= col_valid_i && win_full_i && last_col_i;
            clr_q   <= 1'b0;
        end
    end

    assign sum_o.valid  = valid_q;
    assign sum_o.sum    = win_sum_q;
    assign sum_o.center = ctr_sh_q[CENTER_IDX];
    assign sum_o.last   = last_q;
    assign sum_o.clr    = clr_q;

    // running add and subtract must stay within a full-scale window.
    a_sum_range : assert property (
        @(posedge clk) disable iff (rst)
        win_sum_q <= sum_t'(WIN_SUM_MAX)
    );

endmodule

// ==== files.f ====
ci_geom_pkg.sv
ci_ctrl_pkg.sv
win_sum_if.sv
ci_controller.sv
ci_window_sum.sv
ci_threshold.sv
ci_r8_top.sv
tb_ci_r8.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_ci_r8 \
    -Mdir "$OBJ_DIR" \
    -f files.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vtb_ci_r8" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the outcome.
if grep -q "^Testbench passed$" "$SIM_LOG"; then
    exit 0
fi
echo "no pass line found in $SIM_LOG"
exit 1

// ==== tb_ci_r8.sv ====
`timescale 1ns/1ps

module tb_ci_r8;
    import ci_geom_pkg::*;

    localparam int          IMG_COLS   = 19;
    localparam int          IMG_ROWS   = 19;
    localparam int          N_BANDS    = IMG_ROWS - WIN + 1;
    localparam int          N_RESULTS  = N_BANDS * (IMG_COLS - WIN + 1);
    localparam int          CLK_HALF   = 50;
    localparam int          RST_CYCLES = 8;
    localparam int          WAIT_MAX   = 200;
    localparam int          N_ENTRIES  = 8;
    localparam int unsigned SEED       = 32'hcea5;

    typedef enum {PAT_CONST, PAT_RAMP, PAT_RAND, PAT_SPIKE} pat_e;

    typedef struct {
        pat_e kind;
        int   base;
        bit   gaps;      // 0 to 3 idle cycles between strobes.
        bit   mid_rst;
    } entry_t;

    logic    clk;
    logic    rst;
    logic    col_valid;
    column_t col_data;
    logic    ci;
    logic    ci_valid;
    logic    done;
    logic    progress_done;

    entry_t      stim_tab [N_ENTRIES];
    pixel_t      img [IMG_ROWS][IMG_COLS];
    bit          exp_ci_q [$];
    bit          exp_last_q [$];
    int          checks;
    int          mism_cnt;
    int          fail_cnt;
    int          res_cnt;
    int          done_cnt;

    ci_r8_top #(
        .COLS (IMG_COLS),
        .ROWS (IMG_ROWS)
    ) dut0 (
        .clk             (clk),
        .rst             (rst),
        .col_valid_i     (col_valid),
        .col_i           (col_data),
        .ci_o            (ci),
        .ci_valid_o      (ci_valid),
        .done_o          (done),
        .progress_done_o (progress_done)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            mism_cnt++;
        end
    endtask

    // mean of the window at band b, first column c0, against its center pixel.
    function automatic bit model_ci(input int b, input int c0);
        int sum;
        int quo;
        int rem;
        int ctr;
        sum = 0;
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN; c++) begin
                sum += int'(img[b + r][c0 + c]);
            end
        end
        quo = sum / WIN_AREA;
        rem = sum % WIN_AREA;
        ctr = int'(img[b + CENTER_IDX][c0 + CENTER_IDX]);
        return (ctr > quo) || ((ctr == quo) && (rem == 0));
    endfunction

    task automatic build_image(input pat_e kind, input int base);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                case (kind)
                    PAT_RAMP: img[r][c] = pixel_t'(base + r * 8 + c * 3);
                    PAT_RAND: img[r][c] = pixel_t'($urandom);
                    default:  img[r][c] = pixel_t'(base);
                endcase
            end
        end
        if (kind == PAT_SPIKE) begin
            img[IMG_ROWS / 2][IMG_COLS / 2] = pixel_t'(base - 1);   // center one below the mean.
        end
    endtask

    // nothing is outstanding once reset starts, so any strobe from here on is stale.
    task automatic apply_reset();
        exp_ci_q.delete();
        exp_last_q.delete();
        res_cnt   = 0;
        done_cnt  = 0;
        rst       = 1'b1;
        col_valid = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst       = 1'b0;
    endtask

    // called on a falling edge, returns on the next one.
    task automatic send_column(input int b, input int c);
        column_t col;
        for (int r = 0; r < WIN; r++) begin
            col[r] = img[b + r][c];
        end
        col_data  = col;
        col_valid = 1'b1;
        @(negedge clk);
        col_valid = 1'b0;
    endtask

    task automatic stream_image(input bit gaps, input int max_strobes);
        int n;
        int gap;
        n = 0;
        for (int b = 0; b < N_BANDS; b++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                if (n < max_strobes) begin
                    check_value("progress_done_o", 32'(progress_done), 32'h0);
                    if (c >= WIN - 1) begin
                        exp_ci_q.push_back(model_ci(b, c - WIN + 1));
                        exp_last_q.push_back((b == N_BANDS - 1) && (c == IMG_COLS - 1));
                    end
                    send_column(b, c);
                    n++;
                    if (gaps) begin
                        gap = int'($urandom % 4);
                        repeat (gap) @(negedge clk);
                    end
                end
            end
        end
    endtask

    task automatic wait_progress();
        int cyc;
        cyc = 0;
        while ((progress_done !== 1'b1) && (cyc < WAIT_MAX)) begin
            @(negedge clk);
            cyc++;
        end
        if (progress_done !== 1'b1) begin
            $display("timeout: progress_done_o never rose after the last column");
            fail_cnt++;
        end
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while ((exp_ci_q.size() != 0) && (cyc < WAIT_MAX)) begin
            @(negedge clk);
            cyc++;
        end
        if (exp_ci_q.size() != 0) begin
            $display("timeout: %0d expected results never came out", exp_ci_q.size());
            fail_cnt++;
            exp_ci_q.delete();
            exp_last_q.delete();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if ((done === 1'b1) && (ci_valid !== 1'b1)) begin
            $display("done_o pulsed without a result strobe at %0t", $time);
            fail_cnt++;
        end
        if (ci_valid === 1'b1) begin
            if (exp_ci_q.size() == 0) begin
                $display("result strobe with no window outstanding at %0t", $time);
                fail_cnt++;
            end else begin
                check_value("ci_o", 32'(ci), 32'(exp_ci_q.pop_front()));
                check_value("done_o", 32'(done), 32'(exp_last_q.pop_front()));
            end
            res_cnt++;
            if (done === 1'b1) begin
                done_cnt++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst       = 1'b1;
        col_valid = 1'b0;
        col_data  = '0;
        checks    = 0;
        mism_cnt  = 0;
        fail_cnt  = 0;
        res_cnt   = 0;
        done_cnt  = 0;
        void'($urandom(SEED));

        stim_tab[0] = '{PAT_CONST, 100, 1'b0, 1'b0};
        stim_tab[1] = '{PAT_CONST, 255, 1'b1, 1'b0};   // full-scale sum.
        stim_tab[2] = '{PAT_SPIKE, 60,  1'b0, 1'b0};
        stim_tab[3] = '{PAT_RAMP,  17,  1'b1, 1'b0};
        stim_tab[4] = '{PAT_RAND,  0,   1'b0, 1'b0};
        stim_tab[5] = '{PAT_RAND,  0,   1'b1, 1'b0};
        stim_tab[6] = '{PAT_RAND,  0,   1'b0, 1'b1};
        stim_tab[7] = '{PAT_SPIKE, 200, 1'b1, 1'b1};

        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_reset();
            build_image(stim_tab[i].kind, stim_tab[i].base);
            if (stim_tab[i].mid_rst) begin
                stream_image(stim_tab[i].gaps, IMG_COLS + WIN);   // one window in flight.
                apply_reset();
                check_value("ci_valid_o", 32'(ci_valid), 32'h0);
                check_value("progress_done_o", 32'(progress_done), 32'h0);
            end
            stream_image(stim_tab[i].gaps, N_BANDS * IMG_COLS);
            wait_progress();
            wait_drain();

            // strobes after the last band must leave no trace.
            for (int c = 0; c < 3; c++) begin
                send_column(N_BANDS - 1, c);
            end
            repeat (12) begin
                @(negedge clk);
                check_value("progress_done_o", 32'(progress_done), 32'h1);
            end
            check_value("result count", 32'(res_cnt), 32'(N_RESULTS));
            check_value("done count", 32'(done_cnt), 32'h1);
        end

        $display("checks %0d, value mismatches %0d, other failures %0d",
                 checks, mism_cnt, fail_cnt);
        if ((mism_cnt == 0) && (fail_cnt == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== win_sum_if.sv ====
`timescale 1ns/1ps

interface win_sum_if;
    import ci_geom_pkg::*;

    logic   valid;     // one finished window.
    sum_t   sum;
    pixel_t center;
    logic   last;      // final window of the image.
    logic   clr;       // flush downstream pipeline.

    modport src (
        output valid,
        output sum,
        output center,
        output last,
        output clr
    );

    modport dst (
        input valid,
        input sum,
        input center,
        input last,
        input clr
    );

endinterface
